/* common/unary_params.svh */
`ifndef UNARY_PARAMS_SVH
`define UNARY_PARAMS_SVH

`define UNARY_IWIDTH 8   // activations and weights including the sign.

`define UNARY_OWIDTH 24  // partial sums.

`define UNARY_COLS 4     // columns in the row.

`endif

/* common/unary_data_pkg.sv */
`default_nettype none

`include "unary_params.svh"

package unary_data_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // datapath types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic signed [`UNARY_IWIDTH-1:0] ifm_t;    // two's complement activation.
    typedef logic        [`UNARY_IWIDTH-2:0] mag_t;    // magnitude with the sign carried apart.
    typedef logic signed [`UNARY_OWIDTH-1:0] psum_t;
    typedef logic        [`UNARY_IWIDTH-2:0] win_cnt_t; // also the comparison sequence.

    // one window covers every magnitude value once.
    localparam int unsigned WIN_LEN = 2 ** (`UNARY_IWIDTH - 1);

endpackage

`default_nettype wire

/* common/unary_ctrl_pkg.sv */
`default_nettype none

`include "unary_params.svh"

package unary_ctrl_pkg;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_LOAD,  // input load and accumulator clear.
        SEQ_RUN,
        SEQ_DONE,
        SEQ_DRAIN  // waits while the staggered columns finish.
    } seq_state_e;

    typedef logic [$clog2(`UNARY_COLS)-1:0] col_idx_t;

endpackage

`default_nettype wire

/* rtl/unary_sequencer.sv */
`default_nettype none

`include "unary_params.svh"

module unary_sequencer
    import unary_data_pkg::*, unary_ctrl_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst_n_i,
    input  wire logic start_i,
    output logic      en_i_o,
    output logic      clr_o_o,
    output logic      en_o_o,
    output logic      mac_done_o,
    output logic      busy_o
);

    seq_state_e state_q;
    win_cnt_t   run_cnt_q;
    col_idx_t   drain_cnt_q;
    logic       go;

    assign go = start_i && !busy_o;  // a start during a run is dropped.

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= SEQ_IDLE;
            run_cnt_q   <= '0;
            drain_cnt_q <= '0;
        end else begin
            case (state_q)
                SEQ_IDLE: begin
                    if (go) state_q <= SEQ_LOAD;
                end
                SEQ_LOAD: begin
                    state_q   <= SEQ_RUN;
                    run_cnt_q <= '0;
                end
                SEQ_RUN: begin
                    run_cnt_q <= run_cnt_q + 1'b1;
                    if (run_cnt_q == win_cnt_t'(WIN_LEN - 1)) state_q <= SEQ_DONE;
                end
                SEQ_DONE: begin
                    state_q     <= SEQ_DRAIN;
                    drain_cnt_q <= '0;
                end
                SEQ_DRAIN: begin
                    drain_cnt_q <= drain_cnt_q + 1'b1;
                    if (drain_cnt_q == col_idx_t'(`UNARY_COLS - 1)) state_q <= SEQ_IDLE;
                end
                default: state_q <= SEQ_IDLE;
            endcase
        end
    end

    // busy stays up one cycle past the drain so it covers the valid pulse.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) busy_o <= 1'b0;
        else          busy_o <= (state_q != SEQ_IDLE) || go;
    end

    assign en_i_o     = (state_q == SEQ_LOAD);
    assign clr_o_o    = (state_q == SEQ_LOAD);  // accumulators clear with the input load.
    assign en_o_o     = (state_q == SEQ_RUN);
    assign mac_done_o = (state_q == SEQ_DONE);

    a_done_after_run: assert property (@(posedge clk) disable iff (!rst_n_i)
        mac_done_o |-> $past(en_i_o, WIN_LEN + 1));  // one full window after the load.

endmodule

`default_nettype wire

/* pe/pe_border.sv */
`default_nettype none

`include "unary_params.svh"

module pe_border
    import unary_data_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst_n_i,
    input  wire logic en_i_i, clr_o_i, en_o_i, mac_done_i,
    input  wire logic en_w_i, clr_w_i,
    input  wire ifm_t ifm_i,
    input  wire logic wght_sign_i,
    input  wire mag_t wght_abs_i,
    output logic      clr_o_o, en_o_o, mac_done_o,
    output logic      ifm_sign_o, ifm_bit_o,
    output win_cnt_t  rand_w_o,
    output logic      wght_sign_o,
    output mag_t      wght_abs_o,
    output logic      prod_o, prod_neg_o,
    output logic      acc_clr_o, acc_en_o, acc_done_o
);

    localparam ifm_t IFM_MIN = ifm_t'(1 << (`UNARY_IWIDTH - 1));

    logic     ifm_sign_q;
    mag_t     ifm_mag_q;
    mag_t     ifm_mag;
    win_cnt_t win_cnt_q;
    win_cnt_t rand_w;
    logic     ifm_bit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sign/magnitude input and stream generation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign ifm_mag = ifm_i[`UNARY_IWIDTH-1] ? mag_t'(-ifm_i) : mag_t'(ifm_i);

    always_ff @(posedge clk) begin
        if (en_i_i) begin
            ifm_sign_q <= ifm_i[`UNARY_IWIDTH-1];
            ifm_mag_q  <= ifm_mag;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i)    win_cnt_q <= '0;
        else if (en_i_i) win_cnt_q <= '0;  // window restarts with each load.
        else if (en_o_i) win_cnt_q <= win_cnt_q + 1'b1;
    end

    assign ifm_bit = (win_cnt_q < ifm_mag_q);  // temporal code with the ones first.
    assign rand_w  = {<<{win_cnt_q}};          // bit reversal spreads the weight ones evenly.

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wght_sign_o <= 1'b0;
            wght_abs_o  <= '0;
        end else if (clr_w_i) begin
            wght_sign_o <= 1'b0;
            wght_abs_o  <= '0;
        end else if (en_w_i) begin
            wght_sign_o <= wght_sign_i;
            wght_abs_o  <= wght_abs_i;
        end
    end

    assign prod_o     = ifm_bit && (rand_w < wght_abs_o);
    assign prod_neg_o = ifm_sign_q ^ wght_sign_o;
    assign acc_clr_o  = clr_o_i;
    assign acc_en_o   = en_o_i;
    assign acc_done_o = mac_done_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fan-out to the next column
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            clr_o_o    <= 1'b0;
            en_o_o     <= 1'b0;
            mac_done_o <= 1'b0;
            ifm_sign_o <= 1'b0;
            ifm_bit_o  <= 1'b0;
            rand_w_o   <= '0;
        end else begin
            clr_o_o    <= clr_o_i;
            en_o_o     <= en_o_i;
            mac_done_o <= mac_done_i;
            ifm_sign_o <= ifm_sign_q;
            ifm_bit_o  <= ifm_bit;
            rand_w_o   <= rand_w;
        end
    end

    a_no_min_ifm: assert property (@(posedge clk) disable iff (!rst_n_i)
        en_i_i |-> ifm_i != IFM_MIN);
    a_no_wload_in_run: assert property (@(posedge clk) disable iff (!rst_n_i)
        en_w_i |-> !en_o_i);

endmodule

`default_nettype wire

/* pe/pe_inner.sv */
`default_nettype none

`include "unary_params.svh"

module pe_inner
    import unary_data_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n_i,
    input  wire logic     clr_o_i, en_o_i, mac_done_i,
    input  wire logic     en_w_i, clr_w_i,
    input  wire logic     ifm_sign_i, ifm_bit_i,
    input  wire win_cnt_t rand_w_i,
    input  wire logic     wght_sign_i,
    input  wire mag_t     wght_abs_i,
    output logic          clr_o_o, en_o_o, mac_done_o,
    output logic          ifm_sign_o, ifm_bit_o,
    output win_cnt_t      rand_w_o,
    output logic          wght_sign_o,
    output mag_t          wght_abs_o,
    output logic          prod_o, prod_neg_o,
    output logic          acc_clr_o, acc_en_o, acc_done_o
);

    // weight stage; the left neighbour's old weight moves in on a load.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wght_sign_o <= 1'b0;
            wght_abs_o  <= '0;
        end else if (clr_w_i) begin
            wght_sign_o <= 1'b0;
            wght_abs_o  <= '0;
        end else if (en_w_i) begin
            wght_sign_o <= wght_sign_i;
            wght_abs_o  <= wght_abs_i;
        end
    end

    assign prod_o     = ifm_bit_i && (rand_w_i < wght_abs_o);
    assign prod_neg_o = ifm_sign_i ^ wght_sign_o;
    assign acc_clr_o  = clr_o_i;
    assign acc_en_o   = en_o_i;
    assign acc_done_o = mac_done_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            clr_o_o    <= 1'b0;
            en_o_o     <= 1'b0;
            mac_done_o <= 1'b0;
            ifm_sign_o <= 1'b0;
            ifm_bit_o  <= 1'b0;
            rand_w_o   <= '0;
        end else begin
            clr_o_o    <= clr_o_i;
            en_o_o     <= en_o_i;
            mac_done_o <= mac_done_i;
            ifm_sign_o <= ifm_sign_i;
            ifm_bit_o  <= ifm_bit_i;
            rand_w_o   <= rand_w_i;
        end
    end

    a_no_wload_in_run: assert property (@(posedge clk) disable iff (!rst_n_i)
        en_w_i |-> !en_o_i);

endmodule

`default_nettype wire

/* pe/unary_acc.sv */
`default_nettype none

`include "unary_params.svh"

module unary_acc
    import unary_data_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n_i,
    input  wire logic  clr_i,
    input  wire logic  en_i,
    input  wire logic  mac_done_i,
    input  wire logic  prod_i,
    input  wire logic  prod_neg_i,
    input  wire psum_t psum_i,
    output psum_t      psum_o
);

    // a window holds at most one product bit per magnitude step.
    localparam psum_t CNT_MAX = psum_t'((1 << (`UNARY_IWIDTH - 1)) - 1);

    psum_t cnt_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q  <= '0;
            psum_o <= '0;
        end else begin
            if (clr_i) begin
                cnt_q <= '0;
            end else if (en_i && prod_i) begin
                cnt_q <= prod_neg_i ? cnt_q - 1'b1 : cnt_q + 1'b1;
            end
            if (mac_done_i) psum_o <= psum_i + cnt_q;  // partial sum from above joins here.
        end
    end

    a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n_i)
        (cnt_q <= CNT_MAX) && (cnt_q >= -CNT_MAX));

endmodule

`default_nettype wire

/* rtl/psum_drain.sv */
`default_nettype none

`include "unary_params.svh"

module psum_drain
    import unary_data_pkg::*, unary_ctrl_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rst_n_i,
    input  wire logic [`UNARY_COLS-1:0]  col_done_i,
    input  wire psum_t [`UNARY_COLS-1:0] psum_i,
    output psum_t [`UNARY_COLS-1:0]      result_o,
    output logic                         result_valid_o
);

    localparam col_idx_t LAST_COL = col_idx_t'(`UNARY_COLS - 1);

    psum_t [`UNARY_COLS-1:0] hold_q;
    psum_t [`UNARY_COLS-1:0] merged;

    // columns finish one cycle apart and park here first.
    always_ff @(posedge clk) begin
        for (int c = 0; c < `UNARY_COLS; c++) begin
            if (col_done_i[c]) hold_q[c] <= psum_i[c];
        end
    end

    always_comb begin
        for (int c = 0; c < `UNARY_COLS; c++) begin
            merged[c] = col_done_i[c] ? psum_i[c] : hold_q[c];
        end
    end

    // the last column releases the whole row at once.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            result_o       <= '0;
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= col_done_i[LAST_COL];
            if (col_done_i[LAST_COL]) result_o <= merged;
        end
    end

endmodule

`default_nettype wire

/* rtl/unary_row_top.sv */
`default_nettype none

`include "unary_params.svh"

module unary_row_top
    import unary_data_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rst_n_i,
    input  wire logic                    start_i,
    input  wire ifm_t                    ifm_i,
    input  wire logic                    wght_load_i,
    input  wire logic                    wght_sign_i,
    input  wire mag_t                    wght_abs_i,
    input  wire logic                    wght_clr_i,
    input  wire psum_t [`UNARY_COLS-1:0] bias_i,
    output logic                         busy_o,
    output psum_t [`UNARY_COLS-1:0]      result_o,
    output logic                         result_valid_o
);

    wire seq_en_i, seq_clr_o, seq_en_o, seq_done;

    // index k carries what column k hands to column k+1.
    wire [`UNARY_COLS-1:0]           fw_clr, fw_en, fw_done, fw_isign, fw_ibit, fw_wsign;
    wire win_cnt_t [`UNARY_COLS-1:0] fw_rand;
    wire mag_t [`UNARY_COLS-1:0]     fw_wabs;

    wire [`UNARY_COLS-1:0]        acc_clr, acc_en, acc_done, prod, prod_neg;
    wire psum_t [`UNARY_COLS-1:0] psum;

    unary_sequencer i_seq (
        .clk(clk), .rst_n_i(rst_n_i), .start_i(start_i),
        .en_i_o(seq_en_i), .clr_o_o(seq_clr_o), .en_o_o(seq_en_o),
        .mac_done_o(seq_done), .busy_o(busy_o)
    );

    pe_border i_pe_border (
        .clk(clk), .rst_n_i(rst_n_i),
        .en_i_i(seq_en_i), .clr_o_i(seq_clr_o), .en_o_i(seq_en_o), .mac_done_i(seq_done),
        .en_w_i(wght_load_i), .clr_w_i(wght_clr_i),
        .ifm_i(ifm_i), .wght_sign_i(wght_sign_i), .wght_abs_i(wght_abs_i),
        .clr_o_o(fw_clr[0]), .en_o_o(fw_en[0]), .mac_done_o(fw_done[0]),
        .ifm_sign_o(fw_isign[0]), .ifm_bit_o(fw_ibit[0]), .rand_w_o(fw_rand[0]),
        .wght_sign_o(fw_wsign[0]), .wght_abs_o(fw_wabs[0]),
        .prod_o(prod[0]), .prod_neg_o(prod_neg[0]),
        .acc_clr_o(acc_clr[0]), .acc_en_o(acc_en[0]), .acc_done_o(acc_done[0])
    );

    for (genvar k = 1; k < `UNARY_COLS; k++) begin : g_inner
        pe_inner i_pe (
            .clk(clk), .rst_n_i(rst_n_i),
            .clr_o_i(fw_clr[k-1]), .en_o_i(fw_en[k-1]), .mac_done_i(fw_done[k-1]),
            .en_w_i(wght_load_i), .clr_w_i(wght_clr_i),
            .ifm_sign_i(fw_isign[k-1]), .ifm_bit_i(fw_ibit[k-1]), .rand_w_i(fw_rand[k-1]),
            .wght_sign_i(fw_wsign[k-1]), .wght_abs_i(fw_wabs[k-1]),
            .clr_o_o(fw_clr[k]), .en_o_o(fw_en[k]), .mac_done_o(fw_done[k]),
            .ifm_sign_o(fw_isign[k]), .ifm_bit_o(fw_ibit[k]), .rand_w_o(fw_rand[k]),
            .wght_sign_o(fw_wsign[k]), .wght_abs_o(fw_wabs[k]),
            .prod_o(prod[k]), .prod_neg_o(prod_neg[k]),
            .acc_clr_o(acc_clr[k]), .acc_en_o(acc_en[k]), .acc_done_o(acc_done[k])
        );
    end

    for (genvar k = 0; k < `UNARY_COLS; k++) begin : g_acc
        unary_acc i_acc (
            .clk(clk), .rst_n_i(rst_n_i),
            .clr_i(acc_clr[k]), .en_i(acc_en[k]), .mac_done_i(acc_done[k]),
            .prod_i(prod[k]), .prod_neg_i(prod_neg[k]),
            .psum_i(bias_i[k]), .psum_o(psum[k])
        );
    end

    // the forwarded done marks the cycle a column's sum is ready.
    psum_drain i_drain (
        .clk(clk), .rst_n_i(rst_n_i),
        .col_done_i(fw_done), .psum_i(psum),
        .result_o(result_o), .result_valid_o(result_valid_o)
    );

endmodule

`default_nettype wire

/* sim/tb_unary_row.sv */
`default_nettype none

`include "unary_params.svh"

module tb_unary_row
    import unary_data_pkg::*;
();

    localparam int NUM_REC    = 6;
    localparam int REC_WORDS  = 14;                    // mode, ifm, 4 weights, 4 biases, 4 results.
    localparam int RUN_CYCLES = 135;                   // start to result_valid_o.
    localparam int MAX_CYCLES = NUM_REC * 150 + 50;

    logic                    clk;
    logic                    rst_n_i;
    logic                    start_i;
    ifm_t                    ifm_i;
    logic                    wght_load_i;
    logic                    wght_sign_i;
    mag_t                    wght_abs_i;
    logic                    wght_clr_i;
    psum_t [`UNARY_COLS-1:0] bias_i;
    logic                    busy_o;
    psum_t [`UNARY_COLS-1:0] result_o;
    logic                    result_valid_o;

    logic [`UNARY_OWIDTH-1:0] pat_mem [0:NUM_REC*REC_WORDS-1];
    int                       cycle_cnt;

    unary_row_top i_dut (
        .clk(clk), .rst_n_i(rst_n_i), .start_i(start_i), .ifm_i(ifm_i),
        .wght_load_i(wght_load_i), .wght_sign_i(wght_sign_i), .wght_abs_i(wght_abs_i),
        .wght_clr_i(wght_clr_i), .bias_i(bias_i),
        .busy_o(busy_o), .result_o(result_o), .result_valid_o(result_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("CHECKS FAILED");
        $fatal(1);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic stop_run();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;  // inputs change and outputs are read away from the edge.
    endtask

    task automatic check_psum(input string name, input psum_t exp_val, input psum_t act_val);
        if (act_val !== exp_val) begin
            $display("Fail at time %0t: %s expected %0d, got %0d", $time, name, exp_val, act_val);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("Fail at time %0t: %s expected %b, got %b", $time, name, exp_val, act_val);
            stop_run();
        end
    endtask

    task automatic check_cycles(input string name, input int exp_val, input int act_val);
        if (act_val != exp_val) begin
            $display("Fail at time %0t: %s expected %0d, got %0d", $time, name, exp_val, act_val);
            stop_run();
        end
    endtask

    task automatic run_record(input int r);
        int   base;
        int   n;
        logic clr_wght;
        logic mid_start;
        base      = r * REC_WORDS;
        clr_wght  = pat_mem[base][0];
        mid_start = pat_mem[base][1];
        for (int i = 0; i < `UNARY_COLS; i++) begin  // first weight ends in the last column.
            wght_load_i = 1'b1;
            wght_sign_i = pat_mem[base+2+i][`UNARY_IWIDTH-1];
            wght_abs_i  = mag_t'(pat_mem[base+2+i]);
            next_cycle();
        end
        wght_load_i = 1'b0;
        if (clr_wght) begin
            wght_clr_i = 1'b1;
            next_cycle();
            wght_clr_i = 1'b0;
        end
        ifm_i = ifm_t'(pat_mem[base+1]);
        for (int c = 0; c < `UNARY_COLS; c++) begin
            bias_i[c] = psum_t'(pat_mem[base+6+c]);
        end
        start_i = 1'b1;
        next_cycle();
        start_i = 1'b0;
        n = 1;
        check_bit("busy_o", 1'b1, busy_o);
        while (!result_valid_o && n < RUN_CYCLES + 5) begin
            start_i = mid_start && (n == RUN_CYCLES / 2);  // must be ignored while busy.
            next_cycle();
            n++;
            check_bit("busy_o", 1'b1, busy_o);
        end
        start_i = mid_start;  // busy still covers the valid cycle.
        if (!result_valid_o) begin
            $display("result_valid_o never arrived for record %0d", r);
            stop_run();
        end
        check_cycles("result_valid_o latency", RUN_CYCLES, n);
        for (int c = 0; c < `UNARY_COLS; c++) begin
            check_psum($sformatf("result_o[%0d]", c), psum_t'(pat_mem[base+10+c]), result_o[c]);
        end
        next_cycle();
        start_i = 1'b0;
        check_bit("result_valid_o", 1'b0, result_valid_o);
        check_bit("busy_o", 1'b0, busy_o);
        for (int c = 0; c < `UNARY_COLS; c++) begin  // results hold after the pulse.
            check_psum($sformatf("result_o[%0d]", c), psum_t'(pat_mem[base+10+c]), result_o[c]);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        rst_n_i     = 1'b0;
        start_i     = 1'b0;
        ifm_i       = '0;
        wght_load_i = 1'b0;
        wght_sign_i = 1'b0;
        wght_abs_i  = '0;
        wght_clr_i  = 1'b0;
        bias_i      = '0;
        $readmemh("sim/unary_row_patterns.txt", pat_mem);
        if ($isunknown(pat_mem[NUM_REC*REC_WORDS-1])) begin
            $display("pattern file is missing or holds fewer than %0d records", NUM_REC);
            stop_run();
        end
        repeat (2) @(posedge clk);
        #10;
        rst_n_i = 1'b1;
        check_bit("busy_o", 1'b0, busy_o);
        check_bit("result_valid_o", 1'b0, result_valid_o);
        for (int c = 0; c < `UNARY_COLS; c++) begin
            check_psum($sformatf("result_o[%0d]", c), '0, result_o[c]);
        end
        for (int r = 0; r < NUM_REC; r++) begin
            run_record(r);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/unary_row_patterns.txt */
// mode ifm w0 w1 w2 w3 bias0 bias1 bias2 bias3 exp0 exp1 exp2 exp3
// mode bit0 clears the weights after loading, bit1 issues a start in mid-run.
// weights are {sign, magnitude} in load order; biases and results per column, 24-bit hex.
// full input, positive weights land in reverse load order.
0 7F 0A 14 1E 28 000000 000000 000000 000000 000028 00001E 000014 00000A
// positive input against mixed weight signs, with bias.
0 7F 32 B2 03 FF 0003E8 FFFFFF 000007 FFFED4 000369 000002 FFFFD5 FFFF06
// negative input against the same weights.
0 81 32 B2 03 FF 0003E8 FFFFFF 000007 FFFED4 000467 FFFFFC 000039 FFFEA2
// input -64 with a start issued mid-run.
2 C0 7F C0 21 81 FFFC18 000005 000000 000040 FFFC19 FFFFF4 000020 000000
// input 32 hits every fourth comparison value.
0 20 05 64 87 40 000100 000010 FFFFFF 123456 000110 00000E 000018 123458
// weights cleared after loading, results equal the biases.
1 7F 7F FF 40 C0 000011 FFFFEE 000200 7FFFFF 000011 FFFFEE 000200 7FFFFF

/* compile.f */
+incdir+common
common/unary_data_pkg.sv
common/unary_ctrl_pkg.sv
rtl/unary_sequencer.sv
pe/pe_border.sv
pe/pe_inner.sv
pe/unary_acc.sv
rtl/psum_drain.sv
rtl/unary_row_top.sv
sim/tb_unary_row.sv

/* Bender.yml */
package:
  name: unary_row

sources:
  - include_dirs:
      - common
    files:
      - common/unary_data_pkg.sv
      - common/unary_ctrl_pkg.sv
      - rtl/unary_sequencer.sv
      - pe/pe_border.sv
      - pe/pe_inner.sv
      - pe/unary_acc.sv
      - rtl/psum_drain.sv
      - rtl/unary_row_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/tb_unary_row.sv
